/* rtl/raycast_cfg.svh */
`ifndef RAYCAST_CFG_SVH
`define RAYCAST_CFG_SVH

// visible screen, kept tiny for short runs
`define SCREEN_W 16
`define SCREEN_H 12

// scan totals incl. blanking
`define H_TOTAL 20
`define V_TOTAL 14

// record FIFO holds a few columns only
`define REC_FIFO_DEPTH 4
// write FIFO absorbs flattener bursts
`define WR_FIFO_DEPTH 8

`endif

/* rtl/video_types_pkg.sv */
`default_nettype none

package video_types_pkg;

    typedef logic [15:0] pix565_t;   // r5 g6 b5 as stored
    typedef logic [23:0] rgb888_t;   // r8 g8 b8 as shown
    typedef logic [4:0]  hcount_t;   // up to H_TOTAL-1
    typedef logic [3:0]  vcount_t;   // up to V_TOTAL-1

    localparam pix565_t CEIL_COLOR  = 16'h3186;  // dark slate
    localparam pix565_t FLOOR_COLOR = 16'h5aeb;  // grey

    // indexed by wall type
    localparam pix565_t WALL_COLOR [4] = '{
        16'hf800,   // red brick
        16'h07e0,   // green moss
        16'h001f,   // blue stone
        16'hffe0    // yellow wood
    };

endpackage

`default_nettype wire

/* rtl/ray_types_pkg.sv */
`default_nettype none

package ray_types_pkg;

    typedef logic [3:0] col_idx_t;      // screen column
    typedef logic [3:0] row_idx_t;      // screen row
    typedef logic [4:0] line_height_t;  // wall rows, may exceed screen height
    typedef logic [1:0] wall_type_t;    // wall material, picks the colour

    // result of one ray, one per screen column
    typedef struct packed {
        col_idx_t     col;
        line_height_t line_height;
        wall_type_t   wall_type;
        logic         side;         // y-side hit, drawn darker
    } column_rec_t;

    // single pixel store into the back bank
    typedef struct packed {
        row_idx_t                 row;
        col_idx_t                 col;
        video_types_pkg::pix565_t pixel;
        logic                     last;  // final pixel of a rendered frame
    } pixel_write_t;

endpackage

`default_nettype wire

/* rtl/column_intake.sv */
`default_nettype none

module column_intake (
    input  wire                        clk_pixel,
    input  wire                        sys_rst,
    input  wire                        rec_req,
    input  wire ray_types_pkg::column_rec_t rec_data,
    input  wire                        out_ready,
    output logic                       rec_ack,
    output logic                       out_valid,
    output ray_types_pkg::column_rec_t out_data
);

    typedef enum logic [1:0] {
        ST_IDLE,        // waiting for a new request
        ST_PUSHED,      // record taken, ack now high
        ST_WAIT_REL     // ack held until source drops req
    } intake_state_t;

    intake_state_t state;

    // offer the record only once per handshake
    assign out_valid = (state == ST_IDLE) && rec_req;
    assign out_data  = rec_data;   // source holds it stable under req
    assign rec_ack   = (state != ST_IDLE);

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:     if (out_valid && out_ready) state <= ST_PUSHED;
                ST_PUSHED:   state <= ST_WAIT_REL;    // source cannot have seen ack yet
                ST_WAIT_REL: if (!rec_req) state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // ack may only answer a live request
    a_ack_needs_req: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        $rose(rec_ack) |-> rec_req);

endmodule

`default_nettype wire

/* rtl/stream_fifo.sv */
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire           clk_pixel,
    input  wire           sys_rst,
    input  wire           in_valid,
    input  wire payload_t in_data,
    input  wire           out_ready,
    output logic          in_ready,
    output logic          out_valid,
    output payload_t      out_data
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;      // one extra bit so full is exact
    logic             do_push;
    logic             do_pop;

    assign in_ready  = (count != (PTR_W+1)'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];   // head shows the cycle after the push
    assign do_push   = in_valid && in_ready;
    assign do_pop    = out_valid && out_ready;

    always_ff @(posedge clk_pixel) begin
        if (do_push) mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none, or push and pop together
            endcase
        end
    end

    // pointers meet again when the count says full
    a_no_overflow: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        (count == (PTR_W+1)'(DEPTH)) |-> (wr_ptr == rd_ptr));

    // and when it says empty
    a_no_underflow: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        (count == '0) |-> (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

/* rtl/column_flattener.sv */
`default_nettype none

`include "raycast_cfg.svh"

module column_flattener (
    input  wire                         clk_pixel,
    input  wire                         sys_rst,
    input  wire                         rec_valid,
    input  wire ray_types_pkg::column_rec_t rec_data,
    input  wire                         wr_ready,
    output logic                        rec_ready,
    output logic                        wr_valid,
    output ray_types_pkg::pixel_write_t wr_data
);

    ray_types_pkg::line_height_t h_clamped;
    ray_types_pkg::row_idx_t     h_rows;
    ray_types_pkg::row_idx_t     top_next;
    ray_types_pkg::row_idx_t     row;         // row being emitted
    ray_types_pkg::row_idx_t     wall_top;    // first wall row
    ray_types_pkg::row_idx_t     wall_end;    // first floor row
    ray_types_pkg::col_idx_t     cur_col;
    ray_types_pkg::wall_type_t   cur_type;
    video_types_pkg::pix565_t    base_pix;
    video_types_pkg::pix565_t    wall_pix;
    logic                        cur_side;
    logic                        busy;
    logic                        last_row;
    logic                        pop;

    // tall walls fill the screen
    assign h_clamped = (rec_data.line_height > ray_types_pkg::line_height_t'(`SCREEN_H)) ?
                       ray_types_pkg::line_height_t'(`SCREEN_H) : rec_data.line_height;
    assign h_rows    = ray_types_pkg::row_idx_t'(h_clamped);
    assign top_next  = (ray_types_pkg::row_idx_t'(`SCREEN_H) - h_rows) >> 1;  // centred, rounds down

    assign last_row  = (row == ray_types_pkg::row_idx_t'(`SCREEN_H - 1));
    assign wr_valid  = busy;
    assign rec_ready = !busy || (wr_ready && last_row);   // back to back columns
    assign pop       = rec_valid && rec_ready;

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            busy <= 1'b0;
            row  <= '0;
        end else if (pop) begin
            busy <= 1'b1;
            row  <= '0;
        end else if (busy && wr_ready) begin
            if (last_row) busy <= 1'b0;
            else          row  <= row + 1'b1;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (pop) begin
            cur_col  <= rec_data.col;
            cur_type <= rec_data.wall_type;
            cur_side <= rec_data.side;
            wall_top <= top_next;
            wall_end <= top_next + h_rows;
        end
    end

    always_comb begin
        base_pix = video_types_pkg::WALL_COLOR[cur_type];
        // side hits get every field halved
        wall_pix = cur_side ? {1'b0, base_pix[15:12], 1'b0, base_pix[10:6],
                               1'b0, base_pix[4:1]} : base_pix;
        wr_data.row  = row;
        wr_data.col  = cur_col;
        wr_data.last = last_row && (cur_col == ray_types_pkg::col_idx_t'(`SCREEN_W - 1));
        if (row < wall_top)      wr_data.pixel = video_types_pkg::CEIL_COLOR;
        else if (row < wall_end) wr_data.pixel = wall_pix;
        else                     wr_data.pixel = video_types_pkg::FLOOR_COLOR;
    end

    a_row_in_range: assert property (@(posedge clk_pixel) disable iff (sys_rst)
        busy |-> row <= ray_types_pkg::row_idx_t'(`SCREEN_H - 1));

endmodule

`default_nettype wire

/* rtl/frame_buffer.sv */
`default_nettype none

`include "raycast_cfg.svh"

module frame_buffer (
    input  wire                          clk_pixel,
    input  wire                          sys_rst,
    input  wire                          wr_valid,
    input  wire ray_types_pkg::pixel_write_t wr_data,
    input  wire video_types_pkg::hcount_t hcount,
    input  wire video_types_pkg::vcount_t vcount,
    input  wire                          active_draw,
    input  wire                          video_new_frame,
    input  wire                          video_last_pixel,
    output logic                         wr_ready,
    output video_types_pkg::rgb888_t     rgb,
    output logic                         frame_shown,
    output video_types_pkg::hcount_t     scan_h,
    output video_types_pkg::vcount_t     scan_v,
    output logic                         scan_active,
    output logic                         new_frame
);

    video_types_pkg::pix565_t mem [2][`SCREEN_H][`SCREEN_W];  // [bank][row][col]
    video_types_pkg::pix565_t rd_pix;
    logic front;          // bank on screen
    logic back;
    logic swap_pending;   // back bank complete, waiting for frame end
    logic show_armed;     // swapped, flag the next frame start
    logic wr_last;

    assign wr_ready = 1'b1;    // a store never stalls
    assign back     = !front;
    assign wr_last  = wr_valid && wr_ready && wr_data.last;

    always_ff @(posedge clk_pixel) begin
        if (wr_valid && wr_ready) mem[back][wr_data.row][wr_data.col] <= wr_data.pixel;
    end

    // read and scan position stay aligned, both one cycle behind the counters
    always_ff @(posedge clk_pixel) begin
        if (active_draw) rd_pix <= mem[front][vcount][ray_types_pkg::col_idx_t'(hcount)];
        scan_h <= hcount;
        scan_v <= vcount;
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            front        <= 1'b0;
            swap_pending <= 1'b0;
            show_armed   <= 1'b0;
            frame_shown  <= 1'b0;
            scan_active  <= 1'b0;
            new_frame    <= 1'b0;
        end else begin
            scan_active <= active_draw;
            new_frame   <= video_new_frame;
            frame_shown <= video_new_frame && show_armed;
            if (video_new_frame) show_armed <= 1'b0;
            if (video_last_pixel && swap_pending) begin
                front        <= back;
                swap_pending <= wr_last;   // a frame finishing right now waits its turn
                show_armed   <= 1'b1;
            end else if (wr_last) begin
                swap_pending <= 1'b1;
            end
        end
    end

    // 565 to 888, top bits copied into the new low bits
    always_comb begin
        if (scan_active) begin
            rgb = {rd_pix[15:11], rd_pix[15:13],
                   rd_pix[10:5],  rd_pix[10:9],
                   rd_pix[4:0],   rd_pix[4:2]};
        end else begin
            rgb = '0;   // blank outside the visible area
        end
    end

endmodule

`default_nettype wire

/* rtl/video_sig_gen.sv */
`default_nettype none

`include "raycast_cfg.svh"

module video_sig_gen (
    input  wire                      clk_pixel,
    input  wire                      sys_rst,
    output video_types_pkg::hcount_t hcount,
    output video_types_pkg::vcount_t vcount,
    output logic                     active_draw,
    output logic                     new_frame,
    output logic                     last_pixel
);

    logic line_end;
    logic frame_end;

    assign line_end  = (hcount == video_types_pkg::hcount_t'(`H_TOTAL - 1));
    assign frame_end = (vcount == video_types_pkg::vcount_t'(`V_TOTAL - 1));

    // nested scan counters, blanking included
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            vcount <= frame_end ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    assign active_draw = (hcount < video_types_pkg::hcount_t'(`SCREEN_W)) &&
                         (vcount < video_types_pkg::vcount_t'(`SCREEN_H));
    assign new_frame   = (hcount == '0) && (vcount == '0);   // top left corner
    assign last_pixel  = line_end && frame_end;              // bottom right of blanking

endmodule

`default_nettype wire

/* rtl/column_renderer.sv */
`default_nettype none

`include "raycast_cfg.svh"

module column_renderer (
    input  wire                          clk_pixel,
    input  wire                          sys_rst,
    input  wire                          rec_req,
    input  wire ray_types_pkg::column_rec_t rec_data,
    output logic                         rec_ack,
    output video_types_pkg::rgb888_t     rgb,
    output video_types_pkg::hcount_t     scan_h,
    output video_types_pkg::vcount_t     scan_v,
    output logic                         scan_active,
    output logic                         new_frame,
    output logic                         frame_shown
);

    logic                        in_valid;    // intake to record FIFO
    logic                        in_ready;
    ray_types_pkg::column_rec_t  in_data;
    logic                        rec_valid;   // record FIFO to flattener
    logic                        rec_ready;
    ray_types_pkg::column_rec_t  rec_head;
    logic                        fl_valid;    // flattener to write FIFO
    logic                        fl_ready;
    ray_types_pkg::pixel_write_t fl_data;
    logic                        wr_valid;    // write FIFO to frame buffer
    logic                        wr_ready;
    ray_types_pkg::pixel_write_t wr_data;
    video_types_pkg::hcount_t    vid_h;
    video_types_pkg::vcount_t    vid_v;
    logic                        vid_active;
    logic                        vid_new_frame;
    logic                        vid_last;

    column_intake intake (
        .clk_pixel(clk_pixel), .sys_rst(sys_rst),
        .rec_req(rec_req), .rec_data(rec_data), .rec_ack(rec_ack),
        .out_valid(in_valid), .out_ready(in_ready), .out_data(in_data));

    stream_fifo #(
        .payload_t(ray_types_pkg::column_rec_t),
        .DEPTH(`REC_FIFO_DEPTH)
    ) rec_fifo (
        .clk_pixel(clk_pixel), .sys_rst(sys_rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .out_valid(rec_valid), .out_ready(rec_ready), .out_data(rec_head));

    column_flattener flattener (
        .clk_pixel(clk_pixel), .sys_rst(sys_rst),
        .rec_valid(rec_valid), .rec_ready(rec_ready), .rec_data(rec_head),
        .wr_valid(fl_valid), .wr_ready(fl_ready), .wr_data(fl_data));

    stream_fifo #(
        .payload_t(ray_types_pkg::pixel_write_t),
        .DEPTH(`WR_FIFO_DEPTH)
    ) wr_fifo (
        .clk_pixel(clk_pixel), .sys_rst(sys_rst),
        .in_valid(fl_valid), .in_ready(fl_ready), .in_data(fl_data),
        .out_valid(wr_valid), .out_ready(wr_ready), .out_data(wr_data));

    video_sig_gen video_gen (
        .clk_pixel(clk_pixel), .sys_rst(sys_rst),
        .hcount(vid_h), .vcount(vid_v), .active_draw(vid_active),
        .new_frame(vid_new_frame), .last_pixel(vid_last));

    frame_buffer fbuf (
        .clk_pixel(clk_pixel), .sys_rst(sys_rst),
        .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_data(wr_data),
        .hcount(vid_h), .vcount(vid_v), .active_draw(vid_active),
        .video_new_frame(vid_new_frame), .video_last_pixel(vid_last),
        .rgb(rgb), .frame_shown(frame_shown),
        .scan_h(scan_h), .scan_v(scan_v), .scan_active(scan_active),
        .new_frame(new_frame));

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk_pixel
);

    initial clk_pixel = 1'b0;

    // free running, 50% duty
    always #(PERIOD / 2) clk_pixel = ~clk_pixel;

endmodule

`default_nettype wire

/* verification/column_renderer_tb.sv */
`default_nettype none

`include "raycast_cfg.svh"

module column_renderer_tb;

    localparam int FRAME_CYCLES = `V_TOTAL * `H_TOTAL;
    localparam int RUN_FRAMES   = 16;                            // about 12 needed
    localparam int WATCHDOG     = RUN_FRAMES * FRAME_CYCLES * 8 + 4000;
    localparam int HS_TIMEOUT   = 2000;                          // cycles per handshake phase

    logic                        clk_pixel;
    logic                        sys_rst;
    logic                        rec_req;
    ray_types_pkg::column_rec_t  rec_data;
    logic                        rec_ack;
    video_types_pkg::rgb888_t    rgb;
    video_types_pkg::hcount_t    scan_h;
    video_types_pkg::vcount_t    scan_v;
    logic                        scan_active;
    logic                        new_frame;
    logic                        frame_shown;

    ray_types_pkg::column_rec_t  next_recs [`SCREEN_W];   // columns as sent
    ray_types_pkg::column_rec_t  disp_recs [`SCREEN_W];   // columns expected on screen
    logic [15:0] lfsr = 16'd52;
    int  shown_count  = 0;
    int  rgb_errors   = 0;
    int  ack_errors   = 0;
    int  scan_errors  = 0;
    int  other_errors = 0;
    int  max_ack_wait = 0;
    int  scan_cycle   = 0;    // compare samples since reset release
    int  exp_h        = 0;
    int  exp_v        = 0;
    logic ack_prev    = 1'b0;

    tb_clock_gen #(.PERIOD(8)) clk_gen (.clk_pixel(clk_pixel));

    column_renderer UUT (
        .clk_pixel(clk_pixel), .sys_rst(sys_rst),
        .rec_req(rec_req), .rec_data(rec_data), .rec_ack(rec_ack),
        .rgb(rgb), .scan_h(scan_h), .scan_v(scan_v), .scan_active(scan_active),
        .new_frame(new_frame), .frame_shown(frame_shown));

    // galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // corners forces all wall types, both sides and the height corner cases
    function automatic ray_types_pkg::column_rec_t make_record(input int c, input bit corners);
        ray_types_pkg::column_rec_t r;
        r.col         = ray_types_pkg::col_idx_t'(c);
        r.line_height = ray_types_pkg::line_height_t'(take_bits(5));
        r.wall_type   = ray_types_pkg::wall_type_t'(take_bits(2));
        r.side        = take_bits(1) != 0;
        if (corners && c < 8) begin
            r.wall_type = ray_types_pkg::wall_type_t'(c % 4);
            r.side      = (c >= 4);
        end
        if (corners && c == 13) r.line_height = '0;                 // ceiling and floor only
        if (corners && c == 14) r.line_height = `SCREEN_H;          // exact full height
        if (corners && c == 15) r.line_height = 5'd31;              // clamped
        return r;
    endfunction

    // expected colour on screen for one pixel
    function automatic video_types_pkg::rgb888_t ref_rgb(input int row, input int col);
        ray_types_pkg::column_rec_t rec;
        video_types_pkg::pix565_t   pix;
        int h, top, r5, g6, b5;
        bit in_wall;
        rec     = disp_recs[col];
        h       = (int'(rec.line_height) > `SCREEN_H) ? `SCREEN_H : int'(rec.line_height);
        top     = (`SCREEN_H - h) / 2;
        in_wall = (row >= top) && (row < top + h);
        if (row < top)    pix = video_types_pkg::CEIL_COLOR;
        else if (in_wall) pix = video_types_pkg::WALL_COLOR[rec.wall_type];
        else              pix = video_types_pkg::FLOOR_COLOR;
        r5 = int'(pix[15:11]);
        g6 = int'(pix[10:5]);
        b5 = int'(pix[4:0]);
        if (in_wall && rec.side) begin
            r5 = r5 / 2;   // darker shade
            g6 = g6 / 2;
            b5 = b5 / 2;
        end
        return {8'(r5 * 8 + r5 / 4), 8'(g6 * 4 + g6 / 16), 8'(b5 * 8 + b5 / 4)};
    endfunction

    task automatic check_rgb(input string name, input video_types_pkg::rgb888_t got,
                             input video_types_pkg::rgb888_t exp);
        if (got !== exp) begin
            rgb_errors++;
            $display("Mismatch %s at row %0d col %0d: got 0x%h, expected 0x%h",
                     name, scan_v, scan_h, got, exp);
        end
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            ack_errors++;
            $display("Mismatch %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            scan_errors++;
            $display("Mismatch %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
        end
    endtask

    task automatic check_pos(input video_types_pkg::hcount_t got_h,
                             input video_types_pkg::vcount_t got_v,
                             input video_types_pkg::hcount_t exp_h_pos,
                             input video_types_pkg::vcount_t exp_v_pos);
        if (got_h !== exp_h_pos || got_v !== exp_v_pos) begin
            scan_errors++;
            $display("Mismatch scan_h/scan_v at %0t: got 0x%h/0x%h, expected 0x%h/0x%h",
                     $time, got_h, got_v, exp_h_pos, exp_v_pos);
        end
    endtask

    task automatic report_counts();
        $display("errors: rgb %0d, ack %0d, scan %0d, other %0d",
                 rgb_errors, ack_errors, scan_errors, other_errors);
    endtask

    // one full four-phase cycle
    task automatic send_record(input ray_types_pkg::column_rec_t r);
        int waited;
        @(negedge clk_pixel);
        check_ack("rec_ack", rec_ack, 1'b0);   // must be idle before a new req
        @(posedge clk_pixel);
        #1;
        rec_data = r;
        rec_req  = 1'b1;
        waited   = 0;
        @(negedge clk_pixel);
        while (!rec_ack && waited < HS_TIMEOUT) begin
            @(negedge clk_pixel);
            waited++;
        end
        if (!rec_ack) begin
            other_errors++;
            $display("rec_ack never rose for column %0d", r.col);
        end
        if (waited > max_ack_wait) max_ack_wait = waited;
        @(posedge clk_pixel);
        #1;
        rec_req = 1'b0;
        waited  = 0;
        @(negedge clk_pixel);
        while (rec_ack && waited < HS_TIMEOUT) begin
            @(negedge clk_pixel);
            waited++;
        end
        if (rec_ack) begin
            other_errors++;
            $display("rec_ack stayed high after rec_req dropped, column %0d", r.col);
        end
    endtask

    task automatic send_columns(input int first, input int last_col, input bit corners);
        for (int c = first; c <= last_col; c++) begin
            next_recs[c] = make_record(c, corners);
            send_record(next_recs[c]);
        end
    endtask

    task automatic wait_shown(input int n);
        int cycles;
        cycles = 0;
        while (shown_count < n && cycles < 3 * FRAME_CYCLES) begin
            @(negedge clk_pixel);
            cycles++;
        end
        if (shown_count < n) begin
            other_errors++;
            $display("frame %0d was never shown", n);
        end
    endtask

    // compare process, sampled mid-cycle
    always @(negedge clk_pixel) begin
        if (!sys_rst) begin
            if (rec_ack && !ack_prev) check_ack("rec_req at rec_ack rise", rec_req, 1'b1);
            ack_prev = rec_ack;
            if (scan_cycle > 0) begin   // scan outputs trail the counters by one cycle
                exp_h = (scan_cycle - 1) % `H_TOTAL;
                exp_v = ((scan_cycle - 1) / `H_TOTAL) % `V_TOTAL;
                check_pos(scan_h, scan_v, video_types_pkg::hcount_t'(exp_h),
                          video_types_pkg::vcount_t'(exp_v));
                check_flag("scan_active", scan_active,
                           (exp_h < `SCREEN_W) && (exp_v < `SCREEN_H));
                check_flag("new_frame", new_frame, (exp_h == 0) && (exp_v == 0));
            end
            scan_cycle++;
            if (frame_shown) begin
                disp_recs   = next_recs;   // new image from this pixel on
                shown_count = shown_count + 1;
            end
            if (!scan_active)         check_rgb("rgb", rgb, '0);
            else if (shown_count > 0) check_rgb("rgb", rgb, ref_rgb(int'(scan_v), int'(scan_h)));
        end
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired after %0d time units, run did not finish", WATCHDOG);
        report_counts();
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        sys_rst  = 1'b1;
        rec_req  = 1'b0;
        rec_data = '0;
        repeat (16) @(posedge clk_pixel);
        #1;
        sys_rst = 1'b0;
        @(negedge clk_pixel);
        check_ack("rec_ack after reset", rec_ack, 1'b0);

        send_columns(0, `SCREEN_W - 1, 1'b1);   // frame 1 with corner cases
        wait_shown(1);
        repeat (2 * FRAME_CYCLES) @(posedge clk_pixel);

        send_columns(0, 7, 1'b0);               // frame 2, first half only
        repeat (3 * FRAME_CYCLES) @(posedge clk_pixel);
        if (shown_count != 1) begin
            other_errors++;
            $display("partly sent frame was shown early, %0d frames shown", shown_count);
        end

        send_columns(8, `SCREEN_W - 1, 1'b0);
        wait_shown(2);
        repeat (2 * FRAME_CYCLES) @(posedge clk_pixel);

        if (max_ack_wait == 0) begin
            other_errors++;
            $display("no request ever waited on a full record FIFO");
        end
        report_counts();
        if (rgb_errors + ack_errors + scan_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* column_renderer.f */
+incdir+rtl
rtl/video_types_pkg.sv
rtl/ray_types_pkg.sv
rtl/column_intake.sv
rtl/stream_fifo.sv
rtl/column_flattener.sv
rtl/frame_buffer.sv
rtl/video_sig_gen.sv
rtl/column_renderer.sv
verification/tb_clock_gen.sv
verification/column_renderer_tb.sv

/* Makefile */
# Verilator build and run for the column renderer

VERILATOR ?= verilator
TOP       ?= column_renderer_tb
RTL_TOP   ?= column_renderer
FILELIST  ?= column_renderer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
